//--- Bender.yml
package:
  name: conv_quad

sources:
  - files:
      - src/conv_pkg.sv
      - src/window_assembler.sv
      - src/quad_mac.sv
      - src/channel_accumulator.sv
      - src/conv_quad_top.sv
  - target: test
    files:
      - dv/conv_quad_checker.sv
      - dv/conv_quad_assertions.sv
      - dv/tb_conv_quad.sv

//--- dv/conv_quad_assertions.sv
`timescale 1ns/1ps

module conv_quad_assertions import conv_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic in_valid,
	input logic out_valid,
	input acc_t res_a,
	input acc_t res_b,
	input acc_t res_c,
	input acc_t res_d
);

	int fails = 0;  // read by the testbench at the end

	// strobe is one cycle wide
	single_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid |=> !out_valid)
		else begin
			fails++;
			$error("out_valid held for two cycles");
		end

	// accepted beat 3 edges before the pulse rose
	beat_behind: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid |-> $past(in_valid, MAC_LATENCY + 2))
		else begin
			fails++;
			$error("out_valid without an accepted beat 3 edges earlier");
		end

	no_x_result: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid |-> !$isunknown({res_a, res_b, res_c, res_d}))
		else begin
			fails++;
			$error("result is X while out_valid is high");
		end

endmodule

//--- dv/conv_quad_checker.sv
`timescale 1ns/1ps

module conv_quad_checker import conv_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic in_valid,
	input logic out_valid,
	input acc_t res_a,
	input acc_t res_b,
	input acc_t res_c,
	input acc_t res_d
);

	acc_t exp_q [$];  // a,b,c,d per group
	int   due_q [$];  // sample index where out_valid must be seen
	int   cyc = 0;
	int   beats = 0;
	int   groups = 0;
	int   pass_cnt = 0;
	int   fail_cnt = 0;
	int   err_cnt = 0;
	bit   seen_first = 0;

	task automatic expect_group(input acc_t a, input acc_t b, input acc_t c, input acc_t d);
		exp_q.push_back(a);
		exp_q.push_back(b);
		exp_q.push_back(c);
		exp_q.push_back(d);
	endtask

	function automatic int compare(string name, acc_t exp, acc_t act);
		if (exp !== act) begin
			$display("Error at %0t: %s expected %0d (%h) actual %0d (%h)",
				$time, name, exp, exp, act, act);
			return 1;
		end
		return 0;
	endfunction

	// samples see the values from the cycle before each edge
	always @(posedge clk) begin
		int bad;
		bad = 0;
		if (rst_n) begin
			cyc++;
			if (in_valid) begin
				beats++;
				// last beat: pulse raised 3 edges on, seen at the sample after
				if (beats % NUM_CHANNELS == 0)
					due_q.push_back(cyc + MAC_LATENCY + 2);
			end
			if (due_q.size() > 0 && due_q[0] < cyc) begin
				$display("out_valid missing at %0t for group %0d", $time, groups);
				void'(due_q.pop_front());
				err_cnt++;
			end
			if (!out_valid && !seen_first && {res_a, res_b, res_c, res_d} !== '0) begin
				$display("results not zero at %0t before the first group", $time);
				err_cnt++;
			end
			if (out_valid) begin
				seen_first = 1;
				if (due_q.size() == 0 || due_q[0] != cyc) begin
					$display("extra or early out_valid at %0t", $time);
					err_cnt++;
				end else if (exp_q.size() < 4) begin
					$display("out_valid at %0t with no expected results queued", $time);
					void'(due_q.pop_front());
					err_cnt++;
				end else begin
					void'(due_q.pop_front());
					bad += compare("res_a", exp_q.pop_front(), res_a);
					bad += compare("res_b", exp_q.pop_front(), res_b);
					bad += compare("res_c", exp_q.pop_front(), res_c);
					bad += compare("res_d", exp_q.pop_front(), res_d);
					if (bad != 0) begin
						fail_cnt++;
						$display("group %0d: FAIL (%0d mismatches)", groups, bad);
					end else begin
						pass_cnt++;
						$display("group %0d: pass", groups);
					end
					groups++;
				end
			end
		end
	end

endmodule

//--- dv/conv_quad_golden.txt
// beat columns: rot weights bank0 bank1 bank2 bank3 (hex)
// after every 20 beats one result line: res_a res_b res_c res_d (32-bit hex)
// group 0, all four rotation codes with uneven counts, mixed signs
0 10F020F01 01020304 FFFEFDFC 05FA07F8 0A14E228
1 10F020F01 01020304 FFFEFDFC 05FA07F8 0A14E228
2 10F020F01 01020304 FFFEFDFC 05FA07F8 0A14E228
3 10F020F01 01020304 FFFEFDFC 05FA07F8 0A14E228
0 10F020F01 01020304 FFFEFDFC 05FA07F8 0A14E228
0 10F020F01 01020304 FFFEFDFC 05FA07F8 0A14E228
1 10F020F01 01020304 FFFEFDFC 05FA07F8 0A14E228
0 10F020F01 01020304 FFFEFDFC 05FA07F8 0A14E228
2 10F020F01 01020304 FFFEFDFC 05FA07F8 0A14E228
0 10F020F01 01020304 FFFEFDFC 05FA07F8 0A14E228
1 10F020F01 01020304 FFFEFDFC 05FA07F8 0A14E228
0 10F020F01 01020304 FFFEFDFC 05FA07F8 0A14E228
0 10F020F01 01020304 FFFEFDFC 05FA07F8 0A14E228
1 10F020F01 01020304 FFFEFDFC 05FA07F8 0A14E228
0 10F020F01 01020304 FFFEFDFC 05FA07F8 0A14E228
2 10F020F01 01020304 FFFEFDFC 05FA07F8 0A14E228
0 10F020F01 01020304 FFFEFDFC 05FA07F8 0A14E228
1 10F020F01 01020304 FFFEFDFC 05FA07F8 0A14E228
0 10F020F01 01020304 FFFEFDFC 05FA07F8 0A14E228
0 10F020F01 01020304 FFFEFDFC 05FA07F8 0A14E228
0000006C FFFFFFAE FFFFFFD0 000001EA
// group 1, all-ones kernel under rotation 3, driven with idle gaps
3 111111111 01020304 FFFEFDFC 05FA07F8 0A14E228
3 111111111 01020304 FFFEFDFC 05FA07F8 0A14E228
3 111111111 01020304 FFFEFDFC 05FA07F8 0A14E228
3 111111111 01020304 FFFEFDFC 05FA07F8 0A14E228
3 111111111 01020304 FFFEFDFC 05FA07F8 0A14E228
3 111111111 01020304 FFFEFDFC 05FA07F8 0A14E228
3 111111111 01020304 FFFEFDFC 05FA07F8 0A14E228
3 111111111 01020304 FFFEFDFC 05FA07F8 0A14E228
3 111111111 01020304 FFFEFDFC 05FA07F8 0A14E228
3 111111111 01020304 FFFEFDFC 05FA07F8 0A14E228
3 111111111 01020304 FFFEFDFC 05FA07F8 0A14E228
3 111111111 01020304 FFFEFDFC 05FA07F8 0A14E228
3 111111111 01020304 FFFEFDFC 05FA07F8 0A14E228
3 111111111 01020304 FFFEFDFC 05FA07F8 0A14E228
3 111111111 01020304 FFFEFDFC 05FA07F8 0A14E228
3 111111111 01020304 FFFEFDFC 05FA07F8 0A14E228
3 111111111 01020304 FFFEFDFC 05FA07F8 0A14E228
3 111111111 01020304 FFFEFDFC 05FA07F8 0A14E228
3 111111111 01020304 FFFEFDFC 05FA07F8 0A14E228
3 111111111 01020304 FFFEFDFC 05FA07F8 0A14E228
000003E8 0000049C 000000DC 0000035C
// group 2, extremes: rows 0-1 of -128, rows 2-3 of 127, weights 7 and -8
0 777777888 80808080 80808080 7F7F7F7F 7F7F7F7F
0 777777888 80808080 80808080 7F7F7F7F 7F7F7F7F
0 777777888 80808080 80808080 7F7F7F7F 7F7F7F7F
0 777777888 80808080 80808080 7F7F7F7F 7F7F7F7F
0 777777888 80808080 80808080 7F7F7F7F 7F7F7F7F
0 777777888 80808080 80808080 7F7F7F7F 7F7F7F7F
0 777777888 80808080 80808080 7F7F7F7F 7F7F7F7F
0 777777888 80808080 80808080 7F7F7F7F 7F7F7F7F
0 777777888 80808080 80808080 7F7F7F7F 7F7F7F7F
0 777777888 80808080 80808080 7F7F7F7F 7F7F7F7F
0 777777888 80808080 80808080 7F7F7F7F 7F7F7F7F
0 777777888 80808080 80808080 7F7F7F7F 7F7F7F7F
0 777777888 80808080 80808080 7F7F7F7F 7F7F7F7F
0 777777888 80808080 80808080 7F7F7F7F 7F7F7F7F
0 777777888 80808080 80808080 7F7F7F7F 7F7F7F7F
0 777777888 80808080 80808080 7F7F7F7F 7F7F7F7F
0 777777888 80808080 80808080 7F7F7F7F 7F7F7F7F
0 777777888 80808080 80808080 7F7F7F7F 7F7F7F7F
0 777777888 80808080 80808080 7F7F7F7F 7F7F7F7F
0 777777888 80808080 80808080 7F7F7F7F 7F7F7F7F
FFFD6DE0 FFFD6DE0 FFFF103C FFFF103C

//--- dv/tb_conv_quad.sv
`timescale 1ns/1ps

module tb_conv_quad import conv_pkg::*; ();

	localparam time PERIOD      = 100ns;
	localparam int  GROUPS      = 3;
	localparam int  BEAT_WORDS  = 6;                            // rot, weights, 4 banks
	localparam int  GROUP_WORDS = NUM_CHANNELS*BEAT_WORDS + 4;  // beats then results

	logic         clk;
	logic         rst_n;
	logic         in_valid;
	bank_word_t   bank0;
	bank_word_t   bank1;
	bank_word_t   bank2;
	bank_word_t   bank3;
	rot_t         rot;
	weight_word_t weights;
	logic         out_valid;
	acc_t         res_a;
	acc_t         res_b;
	acc_t         res_c;
	acc_t         res_d;

	logic [35:0] gold [0:GROUPS*GROUP_WORDS-1];
	integer      seed = 32'hade5;

	conv_quad_top DUT (.*);

	conv_quad_checker chk (
		.clk(clk), .rst_n(rst_n), .in_valid(in_valid), .out_valid(out_valid),
		.res_a(res_a), .res_b(res_b), .res_c(res_c), .res_d(res_d)
	);

	bind conv_quad_top conv_quad_assertions u_assertions (
		.clk(clk), .rst_n(rst_n), .in_valid(in_valid), .out_valid(out_valid),
		.res_a(res_a), .res_b(res_b), .res_c(res_c), .res_d(res_d)
	);

	initial clk = 1'b0;
	always #(PERIOD/2) clk = ~clk;

	// beats * 4 cycles worst case, plus slack for reset and drain
	initial begin
		#((GROUPS*NUM_CHANNELS*4 + 20) * PERIOD);
		$display("timeout: not all result groups arrived in time");
		$display("Test failed");
		$finish;
	end

	task automatic apply_beat(input int base);
		@(posedge clk);
		#1;
		in_valid = 1'b1;
		rot      = rot_t'(gold[base]);
		weights  = gold[base+1];
		bank0    = bank_word_t'(gold[base+2]);
		bank1    = bank_word_t'(gold[base+3]);
		bank2    = bank_word_t'(gold[base+4]);
		bank3    = bank_word_t'(gold[base+5]);
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge clk);
			#1 in_valid = 1'b0;
		end
	endtask

	initial begin
		int base;
		int gap;
		int fails;
		int gold_bad;
		in_valid = 1'b0;
		bank0    = '0;
		bank1    = '0;
		bank2    = '0;
		bank3    = '0;
		rot      = '0;
		weights  = '0;
		rst_n    = 1'b0;
		gold_bad = 0;
		$readmemh("dv/conv_quad_golden.txt", gold);
		if ($isunknown(gold[GROUPS*GROUP_WORDS-1])) begin
			$display("golden file missing or short");
			gold_bad = 1;
		end
		repeat (3) @(posedge clk);
		#1 rst_n = 1'b1;

		for (int g = 0; g < GROUPS; g++) begin
			base = g * GROUP_WORDS;
			chk.expect_group(acc_t'(gold[base + NUM_CHANNELS*BEAT_WORDS]),
				acc_t'(gold[base + NUM_CHANNELS*BEAT_WORDS + 1]),
				acc_t'(gold[base + NUM_CHANNELS*BEAT_WORDS + 2]),
				acc_t'(gold[base + NUM_CHANNELS*BEAT_WORDS + 3]));
			for (int b = 0; b < NUM_CHANNELS; b++) begin
				if (g == 1) begin  // spaced-out group
					gap = {$random(seed)} % 4;
					idle_cycles(gap);
				end
				apply_beat(base + b*BEAT_WORDS);
			end
		end
		idle_cycles(1);

		wait (chk.groups == GROUPS);
		idle_cycles(6);  // catch stray pulses after the last group

		fails = chk.fail_cnt + chk.err_cnt + DUT.u_assertions.fails + gold_bad;
		$display("groups passed %0d, groups failed %0d, other errors %0d, assertion failures %0d",
			chk.pass_cnt, chk.fail_cnt, chk.err_cnt, DUT.u_assertions.fails);
		if (fails == 0 && chk.pass_cnt == GROUPS) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

//--- sim.f
src/conv_pkg.sv
src/window_assembler.sv
src/quad_mac.sv
src/channel_accumulator.sv
src/conv_quad_top.sv
dv/conv_quad_checker.sv
dv/conv_quad_assertions.sv
dv/tb_conv_quad.sv

//--- src/channel_accumulator.sv
`timescale 1ns/1ps

module channel_accumulator import conv_pkg::*; (
	input  logic clk,
	input  logic rst_n,
	input  logic valid_m,
	input  acc_t sum_a,
	input  acc_t sum_b,
	input  acc_t sum_c,
	input  acc_t sum_d,
	output logic out_valid,
	output acc_t res_a,
	output acc_t res_b,
	output acc_t res_c,
	output acc_t res_d
);

	chan_cnt_t cnt;        // channels seen in the current group
	acc_t      cur [4];    // this beat's sums
	acc_t      run [4];    // running sums, channels 0 .. cnt-1
	acc_t      res_q [4];  // last finished group
	logic      last_chan;

	assign cur[0] = sum_a;
	assign cur[1] = sum_b;
	assign cur[2] = sum_c;
	assign cur[3] = sum_d;

	assign last_chan = (cnt == chan_cnt_t'(NUM_CHANNELS - 1));

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cnt       <= '0;
			out_valid <= 1'b0;
			run       <= '{default: '0};
			res_q     <= '{default: '0};
		end else begin
			out_valid <= 1'b0;  // single-cycle strobe
			if (valid_m) begin
				if (last_chan) begin
					// close the group, results hold until the next one
					for (int p = 0; p < 4; p++) begin
						res_q[p] <= run[p] + cur[p];
					end
					out_valid <= 1'b1;
					cnt       <= '0;
				end else begin
					for (int p = 0; p < 4; p++) begin
						run[p] <= (cnt == '0) ? cur[p] : run[p] + cur[p];  // first chan loads
					end
					cnt <= cnt + 1'b1;
				end
			end
		end
	end

	assign res_a = res_q[0];
	assign res_b = res_q[1];
	assign res_c = res_q[2];
	assign res_d = res_q[3];

endmodule

//--- src/conv_pkg.sv
package conv_pkg;

	// pixel and weight precision
	localparam int PIXEL_W  = 8;  // signed activation
	localparam int WEIGHT_W = 4;  // signed kernel tap

	// geometry
	localparam int TAPS  = 9;  // 3x3 kernel
	localparam int WIN   = 4;  // 4x4 window -> 2x2 output block
	localparam int BANKS = 4;  // one 2x2 tile per bank word

	// accumulation
	localparam int ACC_W        = 32;
	localparam int NUM_CHANNELS = 20;  // input channels per output group

	// beat accepted -> row sums registered, combined sum seen by accumulator
	localparam int MAC_LATENCY = 2;

	typedef logic signed [PIXEL_W-1:0]  pixel_t;
	typedef logic signed [WEIGHT_W-1:0] weight_t;

	// 2x2 tile, top row in the upper half
	typedef logic [4*PIXEL_W-1:0] bank_word_t;

	// tap 0 (top left) in the msbs, row major
	typedef logic [TAPS*WEIGHT_W-1:0] weight_word_t;

	// bit 1 swaps tile rows, bit 0 swaps tile columns
	typedef logic [1:0] rot_t;

	typedef logic signed [ACC_W-1:0] acc_t;

	typedef logic [$clog2(NUM_CHANNELS)-1:0] chan_cnt_t;  // 5 bits for 20 channels

endpackage

//--- src/conv_quad_top.sv
`timescale 1ns/1ps

module conv_quad_top import conv_pkg::*; (
	input  logic         clk,
	input  logic         rst_n,
	input  logic         in_valid,   // one channel beat per high cycle
	input  bank_word_t   bank0,
	input  bank_word_t   bank1,
	input  bank_word_t   bank2,
	input  bank_word_t   bank3,
	input  rot_t         rot,
	input  weight_word_t weights,
	output logic         out_valid,  // one pulse per NUM_CHANNELS beats
	output acc_t         res_a,
	output acc_t         res_b,
	output acc_t         res_c,
	output acc_t         res_d
);

	// stage 1 -> stage 2
	logic    valid_w;
	pixel_t  win [WIN*WIN];
	weight_t w [TAPS];

	// stage 2 -> stage 3
	logic valid_m;
	acc_t sum_a;
	acc_t sum_b;
	acc_t sum_c;
	acc_t sum_d;

	window_assembler u_window_assembler (
		.clk      (clk),
		.rst_n    (rst_n),
		.in_valid (in_valid),
		.bank0    (bank0),
		.bank1    (bank1),
		.bank2    (bank2),
		.bank3    (bank3),
		.rot      (rot),
		.weights  (weights),
		.valid_w  (valid_w),
		.win      (win),
		.w        (w)
	);

	quad_mac u_quad_mac (
		.clk     (clk),
		.rst_n   (rst_n),
		.valid_w (valid_w),
		.win     (win),
		.w       (w),
		.valid_m (valid_m),
		.sum_a   (sum_a),
		.sum_b   (sum_b),
		.sum_c   (sum_c),
		.sum_d   (sum_d)
	);

	channel_accumulator u_channel_accumulator (
		.clk       (clk),
		.rst_n     (rst_n),
		.valid_m   (valid_m),
		.sum_a     (sum_a),
		.sum_b     (sum_b),
		.sum_c     (sum_c),
		.sum_d     (sum_d),
		.out_valid (out_valid),
		.res_a     (res_a),
		.res_b     (res_b),
		.res_c     (res_c),
		.res_d     (res_d)
	);

endmodule

//--- src/quad_mac.sv
`timescale 1ns/1ps

module quad_mac import conv_pkg::*; (
	input  logic    clk,
	input  logic    rst_n,
	input  logic    valid_w,
	input  pixel_t  win [WIN*WIN],
	input  weight_t w [TAPS],
	output logic    valid_m,
	output acc_t    sum_a,  // position (0,0)
	output acc_t    sum_b,  // position (0,1)
	output acc_t    sum_c,  // position (1,0)
	output acc_t    sum_d   // position (1,1)
);

	// row_d[p][i]: kernel row i applied at output position p
	acc_t row_d [4][3];
	acc_t row_q [4][3];
	acc_t quad_sum [4];

	// p -> (p/2, p%2) gives a,b,c,d in raster order
	always_comb begin
		for (int p = 0; p < 4; p++) begin
			for (int i = 0; i < 3; i++) begin
				row_d[p][i] = '0;
				for (int j = 0; j < 3; j++) begin
					// widen before the multiply so sign survives
					row_d[p][i] = row_d[p][i] +
						acc_t'(win[(p/2 + i)*WIN + p%2 + j]) * acc_t'(w[3*i + j]);
				end
			end
		end
	end

	// first pipe cut sits between the row sums and the final add
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			valid_m <= 1'b0;
			row_q   <= '{default: '{default: '0}};
		end else begin
			valid_m <= valid_w;
			if (valid_w) begin
				row_q <= row_d;
			end
		end
	end

	// three-row add, no register
	// accumulator samples it on the next edge
	always_comb begin
		for (int p = 0; p < 4; p++) begin
			quad_sum[p] = row_q[p][0] + row_q[p][1] + row_q[p][2];
		end
	end

	assign sum_a = quad_sum[0];
	assign sum_b = quad_sum[1];
	assign sum_c = quad_sum[2];
	assign sum_d = quad_sum[3];

endmodule

//--- src/window_assembler.sv
`timescale 1ns/1ps

module window_assembler import conv_pkg::*; (
	input  logic         clk,
	input  logic         rst_n,
	input  logic         in_valid,
	input  bank_word_t   bank0,
	input  bank_word_t   bank1,
	input  bank_word_t   bank2,
	input  bank_word_t   bank3,
	input  rot_t         rot,
	input  weight_word_t weights,
	output logic         valid_w,
	output pixel_t       win [WIN*WIN],  // row major, win[row*WIN + col]
	output weight_t      w [TAPS]        // row major taps
);

	bank_word_t   bank [BANKS];  // beat as accepted
	rot_t         rot_q;
	weight_word_t weights_q;
	logic         valid_a;       // accepted beat waiting for assembly
	pixel_t       win_d [WIN*WIN];
	weight_t      w_d [TAPS];

	// bank feeding tile (tr, tc) under rotation code r
	function automatic int unsigned bank_sel(int unsigned tr, int unsigned tc, rot_t r);
		return 2 * (tr ^ r[1]) + (tc ^ r[0]);
	endfunction

	// pixel k of a tile, k in raster order inside the 2x2
	function automatic pixel_t tile_pix(bank_word_t word, int unsigned k);
		return word[$bits(bank_word_t) - 1 - PIXEL_W*k -: PIXEL_W];
	endfunction

	// acceptance edge, raw beat held for one cycle
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			valid_a   <= 1'b0;
			bank      <= '{default: '0};
			rot_q     <= '0;
			weights_q <= '0;
		end else begin
			valid_a <= in_valid;
			if (in_valid) begin
				bank[0]   <= bank0;
				bank[1]   <= bank1;
				bank[2]   <= bank2;
				bank[3]   <= bank3;
				rot_q     <= rot;
				weights_q <= weights;
			end
		end
	end

	// scatter the four tiles into the window
	always_comb begin
		for (int tr = 0; tr < 2; tr++) begin          // tile row
			for (int tc = 0; tc < 2; tc++) begin      // tile col
				for (int k = 0; k < 4; k++) begin     // pixel inside tile
					win_d[(2*tr + k/2)*WIN + 2*tc + k%2] =
						tile_pix(bank[bank_sel(tr, tc, rot_q)], k);
				end
			end
		end
	end

	// weight word split into taps, tap 0 at the top
	always_comb begin
		for (int k = 0; k < TAPS; k++) begin
			w_d[k] = weights_q[WEIGHT_W*(TAPS-1-k) +: WEIGHT_W];
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			valid_w <= 1'b0;
			win     <= '{default: '0};
			w       <= '{default: '0};
		end else begin
			valid_w <= valid_a;  // one stage, no stall
			if (valid_a) begin
				win <= win_d;
				w   <= w_d;      // weights travel with their window
			end
		end
	end

endmodule
